//--- async_fifo.f
common/afifo_pkg.sv
src/gray_sync.sv
async_fifo/fifo_mem.sv
async_fifo/fifo_wr_ptr.sv
async_fifo/fifo_rd_ptr.sv
async_fifo/async_fifo.sv
verif/tb_clk_gen.sv
verif/async_fifo_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  --top-module async_fifo_tb -f async_fifo.f

sim_output=$(./obj_dir/Vasync_fifo_tb)
printf '%s\n' "$sim_output"

if grep -qF -- '*** PASSED ***' <<< "$sim_output"; then
  echo "Simulation passed"
  exit 0
fi

echo "Simulation failed"
exit 1

//--- verif/async_fifo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo_tb;

  import afifo_pkg::*;

  localparam logic [31:0] LFSR_SEED = 32'h92c897fb;
  localparam int RESET_CYCLES   = 16;
  localparam int BURST_LEN      = 20;
  localparam int DRAIN_EXTRA    = 6;
  localparam int SETTLE_CYCLES  = 8;
  localparam int SEGMENTS       = 10;
  localparam int SEG_READS      = 200;
  // Ten segments of about 800 rd_clk cycles at the slowest rate, plus the short phases.
  localparam int TIMEOUT_CYCLES = 20000;

  logic      wr_clk;
  logic      rd_clk;
  logic      wr_rst_n;
  logic      rd_rst_n;
  logic      wr_en;
  logic      rd_en;
  data_t     wr_data;
  data_t     rd_data;
  wr_flags_t wr_flags;
  rd_flags_t rd_flags;

  data_t       model_q[$];
  data_t       exp_data;
  logic [31:0] lfsr_state;
  logic [31:0] wr_rand;
  logic [31:0] rd_rand;
  logic [31:0] main_rand;
  logic [4:0]  wr_rate;
  logic [4:0]  rd_rate;
  logic [4:0]  next_wr_rate;
  logic        wr_exact;
  logic        rd_exact;
  int          check_count;
  int          error_count;
  int          rd_count;
  int          drop_count;
  int          cycle_count;
  int          target;

  tb_clk_gen #(.PERIOD_NS(28)) i_wr_clk_gen (.clk(wr_clk));
  tb_clk_gen #(.PERIOD_NS(40)) i_rd_clk_gen (.clk(rd_clk));

  async_fifo i_async_fifo (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .wr_flags (wr_flags),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .rd_flags (rd_flags)
  );

  // Fibonacci LFSR with taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Access rate in sixteenths of the cycles and never below one in four.
  function automatic logic [4:0] pick_rate(input logic [3:0] r);
    logic [4:0] v;
    v = 5'(r) + 5'd4;
    if (v > 5'd16) begin
      v = 5'd16;
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERR %s: got 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
    end
  endtask

  task automatic check_settled();
    int n;
    n = model_q.size();
    check_value("full", 32'(wr_flags.full), 32'(n == FIFO_DEPTH));
    check_value("afull", 32'(wr_flags.afull), 32'(n >= int'(AFULL_LEVEL)));
    check_value("empty", 32'(rd_flags.empty), 32'(n == 0));
    check_value("aempty", 32'(rd_flags.aempty), 32'(n <= int'(AEMPTY_LEVEL)));
  endtask

  // Stops both sides and lets the pointers cross before the flags are checked.
  task automatic settle();
    @(posedge rd_clk);
    rd_rate = '0;
    @(posedge wr_clk);
    wr_rate = '0;
    repeat (SETTLE_CYCLES) @(posedge rd_clk);
    check_settled();
  endtask

  // Write side.
  initial begin
    wr_en   = 1'b0;
    wr_data = '0;
    forever begin
      @(negedge wr_clk);
      if (wr_exact) begin
        check_value("full", 32'(wr_flags.full), 32'(model_q.size() == FIFO_DEPTH));
        check_value("afull", 32'(wr_flags.afull),
                    32'(model_q.size() >= int'(AFULL_LEVEL)));
      end
      wr_en = 1'b0;
      if (wr_rate != 5'd0) begin
        wr_rand = take_bits(4);
        if ({1'b0, wr_rand[3:0]} < wr_rate) begin
          wr_rand = take_bits(8);
          wr_en   = 1'b1;
          wr_data = wr_rand[7:0];
        end
      end
      // Full cannot change before the next rising edge.
      if (wr_en) begin
        if (!wr_flags.full) begin
          model_q.push_back(wr_data);
        end else begin
          drop_count++;
        end
      end
    end
  end

  // Read side.
  initial begin
    rd_en    = 1'b0;
    exp_data = '0;
    forever begin
      @(negedge rd_clk);
      // rd_data holds the word of the last accepted read.
      check_value("rd_data", 32'(rd_data), 32'(exp_data));
      if (rd_exact) begin
        check_value("empty", 32'(rd_flags.empty), 32'(model_q.size() == 0));
        check_value("aempty", 32'(rd_flags.aempty),
                    32'(model_q.size() <= int'(AEMPTY_LEVEL)));
      end
      rd_en = 1'b0;
      if (rd_rate != 5'd0) begin
        rd_rand = take_bits(4);
        rd_en   = ({1'b0, rd_rand[3:0]} < rd_rate);
      end
      if (rd_en && !rd_flags.empty) begin
        if (model_q.size() == 0) begin
          error_count++;
          $display("Read accepted while the model holds no word at %0t ns", $time);
        end else begin
          exp_data = model_q.pop_front();
          rd_count++;
        end
      end
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge rd_clk);
      cycle_count++;
    end
    $display("Timeout after %0d rd_clk cycles, the run did not complete", cycle_count);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    wr_rst_n    = 1'b0;
    rd_rst_n    = 1'b0;
    wr_rate     = '0;
    rd_rate     = '0;
    wr_exact    = 1'b0;
    rd_exact    = 1'b0;
    lfsr_state  = LFSR_SEED;
    check_count = 0;
    error_count = 0;
    rd_count    = 0;
    drop_count  = 0;
    repeat (RESET_CYCLES) @(posedge rd_clk);
    @(negedge wr_clk);
    wr_rst_n = 1'b1;
    @(negedge rd_clk);
    rd_rst_n = 1'b1;
    repeat (4) @(posedge rd_clk);

    check_value("empty", 32'(rd_flags.empty), 32'd1);
    check_value("aempty", 32'(rd_flags.aempty), 32'd1);
    check_value("full", 32'(wr_flags.full), 32'd0);
    check_value("afull", 32'(wr_flags.afull), 32'd0);
    check_value("rd_data", 32'(rd_data), 32'd0);

    // Write burst with the read side idle. The last writes are dropped.
    @(posedge wr_clk);
    wr_exact = 1'b1;
    wr_rate  = 5'd16;
    repeat (BURST_LEN) @(posedge wr_clk);
    wr_rate = '0;
    repeat (2) @(posedge wr_clk);
    wr_exact = 1'b0;
    check_value("model count", 32'(model_q.size()), 32'(FIFO_DEPTH));
    check_value("dropped writes", 32'(drop_count), 32'(BURST_LEN - FIFO_DEPTH));
    settle();

    // Drain with the write side idle, then read on while empty.
    @(posedge rd_clk);
    rd_exact = 1'b1;
    rd_rate  = 5'd16;
    while (model_q.size() != 0) begin
      @(posedge rd_clk);
    end
    repeat (DRAIN_EXTRA) @(posedge rd_clk);
    rd_rate = '0;
    repeat (2) @(posedge rd_clk);
    rd_exact = 1'b0;
    check_value("drained reads", 32'(rd_count), 32'(FIFO_DEPTH));
    settle();

    for (int seg = 0; seg < SEGMENTS; seg++) begin
      @(posedge rd_clk);
      main_rand    = take_bits(8);
      rd_rate      = pick_rate(main_rand[3:0]);
      next_wr_rate = pick_rate(main_rand[7:4]);
      target       = rd_count + SEG_READS;
      @(posedge wr_clk);
      wr_rate = next_wr_rate;
      while (rd_count < target) begin
        @(posedge rd_clk);
      end
      settle();
    end

    $display("checks=%0d errors=%0d reads=%0d dropped_writes=%0d",
             check_count, error_count, rd_count, drop_count);
    if (error_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  // Starts high, so the first edge after time zero is a falling one.
  initial begin
    clk = 1'b1;
    forever begin
      #(PERIOD_NS / 2) clk = ~clk;
    end
  end

endmodule

`default_nettype wire

//--- async_fifo/async_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo (
  input  logic                 wr_clk,
  input  logic                 wr_rst_n,
  input  logic                 wr_en,
  input  afifo_pkg::data_t     wr_data,
  output afifo_pkg::wr_flags_t wr_flags,
  input  logic                 rd_clk,
  input  logic                 rd_rst_n,
  input  logic                 rd_en,
  output afifo_pkg::data_t     rd_data,
  output afifo_pkg::rd_flags_t rd_flags
);

  import afifo_pkg::*;

  logic  wr_accept;
  addr_t wr_addr;
  ptr_t  wr_gray;
  ptr_t  wr_gray_sync;

  logic  rd_accept;
  addr_t rd_addr;
  ptr_t  rd_gray;
  ptr_t  rd_gray_sync;

  fifo_wr_ptr i_fifo_wr_ptr (
    .wr_clk       (wr_clk),
    .wr_rst_n     (wr_rst_n),
    .wr_en        (wr_en),
    .rd_gray_sync (rd_gray_sync),
    .wr_accept    (wr_accept),
    .wr_addr      (wr_addr),
    .wr_gray      (wr_gray),
    .wr_flags     (wr_flags)
  );

  fifo_rd_ptr i_fifo_rd_ptr (
    .rd_clk       (rd_clk),
    .rd_rst_n     (rd_rst_n),
    .rd_en        (rd_en),
    .wr_gray_sync (wr_gray_sync),
    .rd_accept    (rd_accept),
    .rd_addr      (rd_addr),
    .rd_gray      (rd_gray),
    .rd_flags     (rd_flags)
  );

  // Write pointer into the read domain.
  gray_sync i_wr2rd_sync (
    .clk      (rd_clk),
    .rst_n    (rd_rst_n),
    .gray_in  (wr_gray),
    .gray_out (wr_gray_sync)
  );

  // Read pointer into the write domain.
  gray_sync i_rd2wr_sync (
    .clk      (wr_clk),
    .rst_n    (wr_rst_n),
    .gray_in  (rd_gray),
    .gray_out (rd_gray_sync)
  );

  fifo_mem i_fifo_mem (
    .wr_clk    (wr_clk),
    .wr_accept (wr_accept),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_accept (rd_accept),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

endmodule

`default_nettype wire

//--- async_fifo/fifo_rd_ptr.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_rd_ptr (
  input  logic                 rd_clk,
  input  logic                 rd_rst_n,
  input  logic                 rd_en,
  input  afifo_pkg::ptr_t      wr_gray_sync,
  output logic                 rd_accept,
  output afifo_pkg::addr_t     rd_addr,
  output afifo_pkg::ptr_t      rd_gray,
  output afifo_pkg::rd_flags_t rd_flags
);

  import afifo_pkg::*;

  ptr_t rd_bin;
  ptr_t rd_bin_next;
  ptr_t rd_gray_next;
  ptr_t wr_bin_sync;
  ptr_t fill_next;
  logic empty_next;
  logic aempty_next;

  assign rd_accept = rd_en & ~rd_flags.empty;

  // Address of the next word to read. The memory loads it on rd_accept.
  assign rd_addr = rd_bin[ADDR_WIDTH-1:0];

  always_comb begin
    if (rd_accept) begin
      rd_bin_next = rd_bin + ptr_t'(1);
    end else begin
      rd_bin_next = rd_bin;
    end
  end

  assign rd_gray_next = bin2gray(rd_bin_next);

  assign empty_next = (rd_gray_next == wr_gray_sync);

  // Fill count as seen from the read side.
  assign wr_bin_sync = gray2bin(wr_gray_sync);
  assign fill_next   = wr_bin_sync - rd_bin_next;
  assign aempty_next = (fill_next <= AEMPTY_LEVEL);

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_next;
      rd_gray <= rd_gray_next;
    end
  end

  // Both flags come up set after reset.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_flags.empty  <= 1'b1;
      rd_flags.aempty <= 1'b1;
    end else begin
      rd_flags.empty  <= empty_next;
      rd_flags.aempty <= aempty_next;
    end
  end

endmodule

`default_nettype wire

//--- async_fifo/fifo_wr_ptr.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_wr_ptr (
  input  logic                 wr_clk,
  input  logic                 wr_rst_n,
  input  logic                 wr_en,
  input  afifo_pkg::ptr_t      rd_gray_sync,
  output logic                 wr_accept,
  output afifo_pkg::addr_t     wr_addr,
  output afifo_pkg::ptr_t      wr_gray,
  output afifo_pkg::wr_flags_t wr_flags
);

  import afifo_pkg::*;

  ptr_t wr_bin;
  ptr_t wr_bin_next;
  ptr_t wr_gray_next;
  ptr_t rd_bin_sync;
  ptr_t rd_gray_full;
  ptr_t fill_next;
  logic full_next;
  logic afull_next;

  // Writes while full are dropped here and never reach the memory.
  assign wr_accept = wr_en & ~wr_flags.full;

  assign wr_addr = wr_bin[ADDR_WIDTH-1:0];

  always_comb begin
    if (wr_accept) begin
      wr_bin_next = wr_bin + ptr_t'(1);
    end else begin
      wr_bin_next = wr_bin;
    end
  end

  assign wr_gray_next = bin2gray(wr_bin_next);

  // Full when the pointers differ only in the two top Gray bits.
  assign rd_gray_full = {~rd_gray_sync[PTR_WIDTH-1 -: 2], rd_gray_sync[PTR_WIDTH-3:0]};
  assign full_next    = (wr_gray_next == rd_gray_full);

  assign rd_bin_sync = gray2bin(rd_gray_sync);
  assign fill_next   = wr_bin_next - rd_bin_sync;
  assign afull_next  = (fill_next >= AFULL_LEVEL);

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else begin
      wr_bin  <= wr_bin_next;
      wr_gray <= wr_gray_next;
    end
  end

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_flags.full  <= 1'b0;
      wr_flags.afull <= 1'b0;
    end else begin
      wr_flags.full  <= full_next;
      wr_flags.afull <= afull_next;
    end
  end

endmodule

`default_nettype wire

//--- async_fifo/fifo_mem.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_mem (
  input  logic             wr_clk,
  input  logic             wr_accept,
  input  afifo_pkg::addr_t wr_addr,
  input  afifo_pkg::data_t wr_data,
  input  logic             rd_clk,
  input  logic             rd_rst_n,
  input  logic             rd_accept,
  input  afifo_pkg::addr_t rd_addr,
  output afifo_pkg::data_t rd_data
);

  import afifo_pkg::*;

  data_t mem [FIFO_DEPTH];

  always_ff @(posedge wr_clk) begin
    if (wr_accept) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read word holds until the next accepted read.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_accept) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

//--- src/gray_sync.sv
`timescale 1ns/1ps
`default_nettype none

module gray_sync (
  input  logic            clk,
  input  logic            rst_n,
  input  afifo_pkg::ptr_t gray_in,
  output afifo_pkg::ptr_t gray_out
);

  import afifo_pkg::*;

  // First stage may go metastable. Only one Gray bit moves per step.
  ptr_t meta_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      meta_q   <= '0;
      gray_out <= '0;
    end else begin
      meta_q   <= gray_in;
      gray_out <= meta_q;
    end
  end

endmodule

`default_nettype wire

//--- common/afifo_pkg.sv
`default_nettype none

package afifo_pkg;

  localparam int DATA_WIDTH = 8;
  localparam int ADDR_WIDTH = 4;
  localparam int FIFO_DEPTH = 1 << ADDR_WIDTH;
  // One wrap bit above the address.
  localparam int PTR_WIDTH  = ADDR_WIDTH + 1;

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [PTR_WIDTH-1:0]  ptr_t;

  // Fill thresholds in words.
  localparam ptr_t AFULL_LEVEL  = ptr_t'(14);
  localparam ptr_t AEMPTY_LEVEL = ptr_t'(2);

  typedef struct packed {
    logic full;
    logic afull;
  } wr_flags_t;

  typedef struct packed {
    logic empty;
    logic aempty;
  } rd_flags_t;

  function automatic ptr_t bin2gray(ptr_t bin);
    return (bin >> 1) ^ bin;
  endfunction

  function automatic ptr_t gray2bin(ptr_t gray);
    ptr_t bin;
    bin[PTR_WIDTH-1] = gray[PTR_WIDTH-1];
    for (int i = PTR_WIDTH - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

`default_nettype wire
